//--- femtoAlu.sv
// Integer ALU: add/sub, compares, logic ops, branch test and a 1-bit-per-cycle shifter
module femtoAlu import femtoPkg::*; (
   input  logic        clk,
   input  decodedInstr dec,
   input  logic [31:0] in1,
   input  logic [31:0] in2,
   input  logic        aluStart,
   output logic [31:0] aluOut,
   output logic [31:0] aluPlus,
   output logic        predicate,
   output logic        aluBusy
);

   logic [32:0] aluMinus;
   logic        lt;
   logic        ltu;
   logic        eq;
   logic        isShift;
   logic [31:0] shiftReg;  // Operand being shifted in place
   logic [4:0]  shamt;     // Remaining shift steps

   assign aluPlus = in1 + in2;  // Also the JALR target

   // One 33-bit subtract serves SUB and every comparison
   assign aluMinus = {1'b1, ~in2} + {1'b0, in1} + 33'd1;
   assign ltu      = aluMinus[32];                            // Borrow out
   assign lt       = (in1[31] ^ in2[31]) ? in1[31] : aluMinus[32];
   assign eq       = (aluMinus[31:0] == 32'd0);

   assign isShift = dec.funct3Is[1] | dec.funct3Is[5];
   assign aluBusy = |shamt;

   // funct3Is is one-hot, so the terms can simply be ORed
   assign aluOut =
      (dec.funct3Is[0] ? (dec.subArith ? aluMinus[31:0] : aluPlus) : 32'd0) |
      (dec.funct3Is[2] ? {31'd0, lt}  : 32'd0) |  // SLT
      (dec.funct3Is[3] ? {31'd0, ltu} : 32'd0) |  // SLTU
      (dec.funct3Is[4] ? in1 ^ in2    : 32'd0) |
      (dec.funct3Is[6] ? in1 | in2    : 32'd0) |
      (dec.funct3Is[7] ? in1 & in2    : 32'd0) |
      (isShift         ? shiftReg     : 32'd0);

   // Branch funct3 values 2 and 3 are reserved and never taken
   assign predicate =
      (dec.funct3Is[0] &  eq)  |  // BEQ
      (dec.funct3Is[1] & ~eq)  |  // BNE
      (dec.funct3Is[4] &  lt)  |  // BLT
      (dec.funct3Is[5] & ~lt)  |  // BGE
      (dec.funct3Is[6] &  ltu) |  // BLTU
      (dec.funct3Is[7] & ~ltu);   // BGEU

   always_ff @(posedge clk) begin
      if (aluStart) begin
         if (isShift) begin
            shiftReg <= in1;
            shamt    <= in2[4:0];  // Only the low 5 bits count in RV32I
         end
      end else if (aluBusy) begin
         shamt <= shamt - 5'd1;
         if (dec.funct3Is[1]) begin
            shiftReg <= shiftReg << 1;  // SLL
         end else begin
            // SRA repeats the sign bit, SRL shifts in zero
            shiftReg <= {dec.subArith & shiftReg[31], shiftReg[31:1]};
         end
      end
   end

endmodule

//--- femtoConfig.svh
// Femto SoC build constants: reset vector, address widths, RAM size and IO map
`ifndef FEMTO_CONFIG_SVH
`define FEMTO_CONFIG_SVH

// First instruction fetch after reset
`define FEMTO_RESET_ADDR 32'h0000_0000

// Width of PC and of the address adders inside the core
`define FEMTO_ADDR_WIDTH 24

// RAM depth in 32-bit words (8 KB)
`define FEMTO_RAM_WORDS 2048

// Address bit that selects the IO page instead of RAM
`define FEMTO_IO_BIT 22

// LED register width
`define FEMTO_LED_WIDTH 8

`endif

//--- femtoCore.sv
// Multi-cycle RV32I core: one-hot sequencer, PC and target adders, write-back, memory port
`include "femtoConfig.svh"

module femtoCore import femtoPkg::*; (
   input  logic        clk,
   input  logic        mem_rstrb,
   output memReq       req,
   input  logic [31:0] rdata
);

   localparam int addrW = `FEMTO_ADDR_WIDTH;
   localparam logic [31:0] resetAddr = `FEMTO_RESET_ADDR;

   coreState    state;
   instrWord    instr;      // Latched during waitInstr
   decodedInstr dec;
   logic [addrW-1:0] pc;
   logic [addrW-1:0] pcPlus4;
   logic [addrW-1:0] pcPlusImm;
   logic [addrW-1:0] lsAddr;
   logic [4:0]  rs1Id;
   logic [4:0]  rs2Id;
   logic [31:0] rs1;
   logic [31:0] rs2;
   logic [31:0] aluIn2;
   logic [31:0] aluOut;
   logic [31:0] aluPlus;
   logic        predicate;
   logic        aluBusy;
   logic        aluStart;
   logic        isAluClass;
   logic        isShift;
   logic        needToWait;
   logic        takeImm;
   logic        wbEn;
   logic [31:0] wbData;
   logic [31:0] loadData;
   logic [31:0] storeData;
   logic [3:0]  storeMask;

   instrDecoder decoder (.instr, .dec);

   // Ids come straight from the bus in waitInstr, later from the latched word
   assign rs1Id = (state == waitInstr) ? rdata[19:15] : instr.rType.rs1;
   assign rs2Id = (state == waitInstr) ? rdata[24:20] : instr.rType.rs2;

   regFile regs (
      .clk, .rs1Id, .rs2Id, .rs1, .rs2,
      .we(wbEn), .rdId(dec.rd), .wdata(wbData)
   );

   assign aluIn2 = (dec.cls == aluReg || dec.cls == branch) ? rs2 : dec.iImm;

   femtoAlu alu (
      .clk, .dec, .in1(rs1), .in2(aluIn2), .aluStart,
      .aluOut, .aluPlus, .predicate, .aluBusy
   );

   loadStoreUnit lsu (
      .rdata, .rs2, .addrLow(lsAddr[1:0]), .funct3(instr.rType.funct3),
      .loadData, .storeData, .storeMask
   );

   assign isAluClass = (dec.cls == aluImm) | (dec.cls == aluReg);
   assign isShift    = isAluClass & (dec.funct3Is[1] | dec.funct3Is[5]);
   assign needToWait = (dec.cls == load) | (dec.cls == store) | isShift;
   assign takeImm    = (dec.cls == jal) | ((dec.cls == branch) & predicate);
   assign aluStart   = (state == execute) & isAluClass;

   assign pcPlus4 = pc + addrW'(4);
   // One adder for branch, JAL and AUIPC targets
   assign pcPlusImm = pc + ((dec.cls == jal)   ? dec.jImm[addrW-1:0] :
                            (dec.cls == auipc) ? dec.uImm[addrW-1:0] :
                                                 dec.bImm[addrW-1:0]);
   assign lsAddr = rs1[addrW-1:0] +
                   ((dec.cls == store) ? dec.sImm[addrW-1:0] : dec.iImm[addrW-1:0]);

   always_comb begin
      unique case (dec.cls)
         lui:         wbData = dec.uImm;
         aluImm,
         aluReg:      wbData = aluOut;
         auipc:       wbData = 32'(pcPlusImm);
         jal, jalr:   wbData = 32'(pcPlus4);  // Link address
         load:        wbData = loadData;
         default:     wbData = 32'd0;
      endcase
   end

   // Single-cycle ops write in execute, loads and shifts on leaving the wait state
   assign wbEn =
      ((state == execute) &
       ((isAluClass & ~isShift) | (dec.cls == jal) | (dec.cls == jalr) |
        (dec.cls == lui) | (dec.cls == auipc))) |
      ((state == waitAluOrMem) & ~aluBusy & ((dec.cls == load) | isShift));

   // Instruction fetch uses PC, data access the load/store address
   assign req.addr = (state == fetchInstr || state == waitInstr) ? 32'(pc) : 32'(lsAddr);
   assign req.wdata      = storeData;
   assign req.wmask      = {4{(state == execute) & (dec.cls == store)}} & storeMask;
   assign req.readStrobe = (state == fetchInstr) | ((state == execute) & (dec.cls == load));

   always_ff @(posedge clk) begin
      if (mem_rstrb) begin
         state <= waitAluOrMem;  // Leaves once the ALU reports idle
         pc    <= resetAddr[addrW-1:0];
      end else begin
         unique case (state)
            fetchInstr: state <= waitInstr;
            waitInstr: begin
               instr <= rdata;  // Operands are read on this same edge
               state <= execute;
            end
            execute: begin
               if (dec.cls == jalr) begin
                  pc <= {aluPlus[addrW-1:1], 1'b0};
               end else if (takeImm) begin
                  pc <= pcPlusImm;
               end else begin
                  pc <= pcPlus4;
               end
               state <= needToWait ? waitAluOrMem : fetchInstr;
            end
            default: begin  // waitAluOrMem
               if (!aluBusy) state <= fetchInstr;
            end
         endcase
      end
   end

endmodule

//--- femtoPkg.sv
// Femto SoC types: instruction formats, decoded fields, memory request, core state
package femtoPkg;

   // RV32I field layouts, one per format, MSB first
   typedef struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
   } rTypeT;

   typedef struct packed {
      logic [11:0] imm11_0;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
   } iTypeT;

   typedef struct packed {
      logic [6:0] imm11_5;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] imm4_0;
      logic [6:0] opcode;
   } sTypeT;

   typedef struct packed {
      logic       imm12;
      logic [5:0] imm10_5;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [3:0] imm4_1;
      logic       imm11;
      logic [6:0] opcode;
   } bTypeT;

   typedef struct packed {
      logic [19:0] imm31_12;
      logic [4:0]  rd;
      logic [6:0]  opcode;
   } uTypeT;

   typedef struct packed {
      logic       imm20;
      logic [9:0] imm10_1;
      logic       imm11;
      logic [7:0] imm19_12;
      logic [4:0] rd;
      logic [6:0] opcode;
   } jTypeT;

   // Same 32 bits, read through whichever format the opcode implies
   typedef union packed {
      rTypeT rType;
      iTypeT iType;
      sTypeT sType;
      bTypeT bType;
      uTypeT uType;
      jTypeT jType;
   } instrWord;

   typedef enum logic [3:0] {
      load, store, aluImm, aluReg, branch, jal, jalr, lui, auipc, illegal
   } opClass;

   typedef struct packed {
      opClass      cls;
      logic [7:0]  funct3Is;  // funct3Is[n] set when funct3 == n
      logic [4:0]  rd;
      logic        subArith;  // SUB, or SRA/SRAI
      logic [31:0] iImm;
      logic [31:0] sImm;
      logic [31:0] bImm;
      logic [31:0] uImm;
      logic [31:0] jImm;
   } decodedInstr;

   typedef struct packed {
      logic [31:0] addr;
      logic [31:0] wdata;
      logic [3:0]  wmask;       // Byte write enables, zero on reads
      logic        readStrobe;
   } memReq;

   typedef enum logic [3:0] {
      fetchInstr   = 4'b0001,
      waitInstr    = 4'b0010,
      execute      = 4'b0100,
      waitAluOrMem = 4'b1000
   } coreState;

endpackage

//--- femtoSoc.sv
// Femto SoC top: core, word-addressed RAM with one-cycle reads, and the LED register
`include "femtoConfig.svh"

module femtoSoc import femtoPkg::*; (
   input  logic                        clk,
   input  logic                        mem_rstrb,
   output logic [`FEMTO_LED_WIDTH-1:0] leds
);

   localparam int ramAddrBits = $clog2(`FEMTO_RAM_WORDS);

   memReq                  req;
   logic [31:0]            rdata;
   logic [31:0]            ramRdata;
   logic                   isIo;
   logic                   ramRead;
   logic [3:0]             ramWmask;
   logic [ramAddrBits-1:0] ramIdx;
   logic [31:0]            ram [`FEMTO_RAM_WORDS];

   femtoCore core (.clk, .mem_rstrb, .req, .rdata);

   assign isIo   = req.addr[`FEMTO_IO_BIT];
   assign ramIdx = req.addr[ramAddrBits+1:2];  // Byte address to word index

   // RAM sees no access while the IO page is selected
   assign ramRead  = req.readStrobe & ~isIo;
   assign ramWmask = req.wmask & {4{~isIo}};

   always_ff @(posedge clk) begin
      if (ramRead) ramRdata <= ram[ramIdx];
      for (int b = 0; b < 4; b++) begin
         if (ramWmask[b]) ram[ramIdx][8*b +: 8] <= req.wdata[8*b +: 8];
      end
   end

   // IO registers are one-hot in the word address, LEDs on bit 0
   always_ff @(posedge clk) begin
      if (mem_rstrb) begin
         leds <= '0;
      end else if (isIo && (|req.wmask) && req.addr[2]) begin
         leds <= req.wdata[`FEMTO_LED_WIDTH-1:0];
      end
   end

   assign rdata = isIo ? 32'd0 : ramRdata;  // Nothing readable in the IO page

endmodule

//--- femtoStim.txt
# P <byte address> <up to 8 instruction words, hex>
# T <test name> <expected LED value, hex>, up to 4 pairs per line
P 000 00400FB7 06400093 FFD00113 FF908293 005FA223 002082B3 005FA223 402082B3
P 020 005FA223 0020C2B3 005FA223 0020E2B3 005FA223 0020F2B3 005FA223 0020A2B3
P 040 005FA223 0020B2B3 005FA223 123452B7 005FA223 00000297 005FA223 800001B7
P 060 0F118193 00019293 005FA223 00119293 005FA223 00719293 005FA223 01F19293
P 080 005FA223 0011D293 005FA223 0071D293 005FA223 41F1D293 005FA223 01F1D293
P 0A0 005FA223 4011D293 005FA223 0001D293 005FA223 4071D293 005FA223 4001D293
P 0C0 005FA223 00001237 08100313 00620023 01200313 006200A3 0A300313 00620123
P 0E0 03400313 006201A3 FFE00313 00621223 7C500313 00621323 00020283 0042D293
P 100 005FA223 00024283 0042D293 005FA223 00120283 0042D293 005FA223 00224283
P 120 0042D293 005FA223 00220283 0042D293 005FA223 00320283 0042D293 005FA223
P 140 00421283 00C2D293 005FA223 00425283 00C2D293 005FA223 00621283 0042D293
P 160 005FA223 00022283 0042D293 005FA223 00422283 0102D293 005FA223 0B000293
P 180 00108463 0EE00293 005FA223 0EE00293 00208463 0B100293 005FA223 0B200293
P 1A0 00209463 0EE00293 005FA223 0EE00293 00109463 0B300293 005FA223 0B400293
P 1C0 00114463 0EE00293 005FA223 0EE00293 0020C463 0B500293 005FA223 0B600293
P 1E0 0020D463 0EE00293 005FA223 0EE00293 00115463 0B700293 005FA223 0B800293
P 200 0020E463 0EE00293 005FA223 0EE00293 00116463 0B900293 005FA223 0BA00293
P 220 00117463 0EE00293 005FA223 0EE00293 0020F463 0BB00293 005FA223 008002EF
P 240 0EE00293 005FA223 00000397 01038393 000382E7 0EE00293 005FA223 0000006F
T addi 5D add 61 sub 67 xor 99
T or FD and 64 slt 00 sltu 01
T lui 00 auipc 54 slli0 F1 slli1 E2
T slli7 80 slli31 00 srli1 78 srli7 01
T srai31 FF srli31 01 srai1 78 srli0 F1
T srai7 01 srai0 F1 lb0 F8 lbu0 08
T lb1 01 lbu2 0A lb2 FA lb3 03
T lh4 FF lhu4 0F lh6 7C lw0 28
T lw4 C5 beqT B0 beqN B1 bneT B2
T bneN B3 bltT B4 bltN B5 bgeT B6
T bgeN B7 bltuT B8 bltuN B9 bgeuT BA
T bgeuN BB jalLink 40 jalrLink 54

//--- instrDecoder.sv
// RV32I decoder: opcode class, one-hot funct3, rd and all five immediate formats
module instrDecoder import femtoPkg::*; (
   input  instrWord    instr,
   output decodedInstr dec
);

   always_comb begin
      // Opcode bits [1:0] are always 11 in RV32I
      unique case (instr.rType.opcode[6:2])
         5'b00000: dec.cls = load;    // rd <- mem[rs1+Iimm]
         5'b01000: dec.cls = store;   // mem[rs1+Simm] <- rs2
         5'b00100: dec.cls = aluImm;  // rd <- rs1 OP Iimm
         5'b01100: dec.cls = aluReg;  // rd <- rs1 OP rs2
         5'b11000: dec.cls = branch;
         5'b11011: dec.cls = jal;
         5'b11001: dec.cls = jalr;
         5'b01101: dec.cls = lui;
         5'b00101: dec.cls = auipc;
         default:  dec.cls = illegal; // SYSTEM, FENCE and the rest
      endcase

      dec.funct3Is = 8'b0000_0001 << instr.rType.funct3;
      dec.rd       = instr.rType.rd;

      // Bit 30 means SUB only for register ops, ADDI uses it as an immediate bit
      dec.subArith = instr.rType.funct7[5] &
                     ((dec.cls == aluReg) | (instr.rType.funct3 == 3'b101));

      dec.iImm = {{20{instr.iType.imm11_0[11]}}, instr.iType.imm11_0};
      dec.sImm = {{20{instr.sType.imm11_5[6]}}, instr.sType.imm11_5,
                  instr.sType.imm4_0};
      dec.bImm = {{19{instr.bType.imm12}}, instr.bType.imm12, instr.bType.imm11,
                  instr.bType.imm10_5, instr.bType.imm4_1, 1'b0};
      dec.uImm = {instr.uType.imm31_12, 12'b0};
      dec.jImm = {{11{instr.jType.imm20}}, instr.jType.imm20, instr.jType.imm19_12,
                  instr.jType.imm11, instr.jType.imm10_1, 1'b0};
   end

endmodule

//--- loadStoreUnit.sv
// Sub-word memory access: load lane select and extension, store lane copy and byte mask
module loadStoreUnit (
   input  logic [31:0] rdata,
   input  logic [31:0] rs2,
   input  logic [1:0]  addrLow,
   input  logic [2:0]  funct3,
   output logic [31:0] loadData,
   output logic [31:0] storeData,
   output logic [3:0]  storeMask
);

   logic        byteAccess;
   logic        halfAccess;
   logic [15:0] loadHalf;
   logic [7:0]  loadByte;
   logic        loadSign;

   assign byteAccess = (funct3[1:0] == 2'b00);
   assign halfAccess = (funct3[1:0] == 2'b01);

   // Halfword lane first, then the byte inside it
   assign loadHalf = addrLow[1] ? rdata[31:16] : rdata[15:0];
   assign loadByte = addrLow[0] ? loadHalf[15:8] : loadHalf[7:0];

   // funct3[2] set for LBU/LHU
   assign loadSign = ~funct3[2] & (byteAccess ? loadByte[7] : loadHalf[15]);

   assign loadData = byteAccess ? {{24{loadSign}}, loadByte} :
                     halfAccess ? {{16{loadSign}}, loadHalf} :
                                  rdata;

   // Place the low byte/halfword on every lane it may land on, the mask picks one
   assign storeData[7:0]   = rs2[7:0];
   assign storeData[15:8]  = addrLow[0] ? rs2[7:0] : rs2[15:8];
   assign storeData[23:16] = addrLow[1] ? rs2[7:0] : rs2[23:16];
   assign storeData[31:24] = addrLow[0] ? rs2[7:0] :
                             addrLow[1] ? rs2[15:8] : rs2[31:24];

   always_comb begin
      if (byteAccess) begin
         storeMask = 4'b0001 << addrLow;
      end else if (halfAccess) begin
         storeMask = addrLow[1] ? 4'b1100 : 4'b0011;
      end else begin
         storeMask = 4'b1111;  // SW
      end
   end

endmodule

//--- regFile.sv
// 32 x 32-bit register file, two registered read ports, x0 hardwired to zero
module regFile (
   input  logic        clk,
   input  logic [4:0]  rs1Id,
   input  logic [4:0]  rs2Id,
   output logic [31:0] rs1,
   output logic [31:0] rs2,
   input  logic        we,
   input  logic [4:0]  rdId,
   input  logic [31:0] wdata
);

   logic [31:0] regs [32];

   always_ff @(posedge clk) begin
      if (we && rdId != 5'd0) begin
         regs[rdId] <= wdata;  // x0 never written
      end
      // Entry 0 is never initialized, so force the zero on read
      rs1 <= (rs1Id == 5'd0) ? 32'd0 : regs[rs1Id];
      rs2 <= (rs2Id == 5'd0) ? 32'd0 : regs[rs2Id];
   end

endmodule

//--- run.sh
#!/bin/sh
set -e
verilator --binary --timing -Wno-fatal -f src.f --top-module tbFemtoSoc
out=$(./obj_dir/VtbFemtoSoc)
echo "$out"
echo "$out" | grep -qx "all tests passed"

//--- src.f
+incdir+.
femtoPkg.sv
instrDecoder.sv
regFile.sv
femtoAlu.sv
loadStoreUnit.sv
femtoCore.sv
femtoSoc.sv
tbFemtoSoc.sv

//--- tbFemtoSoc.sv
// Femto SoC testbench that loads the program, runs it and checks every LED result
`include "femtoConfig.svh"

module tbFemtoSoc;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int cyclesPerResult = 300;  // Watchdog budget per expected value

   logic clk = 1'b0;
   logic mem_rstrb = 1'b1;
   logic [`FEMTO_LED_WIDTH-1:0] leds;

   logic [`FEMTO_LED_WIDTH-1:0] expQ[$];   // Expected LED values in file order
   logic [8*12-1:0]             nameQ[$];  // Test names in the same order
   logic                        loaded = 1'b0;
   int                          errors = 0;
   int                          checks = 0;

   femtoSoc UUT (.clk, .mem_rstrb, .leds);

   always #10 clk = ~clk;  // 20 ns period

   // Reads program words into RAM and expected values into the queues
   task automatic loadStim();
      int          fd;
      int          n;
      string       line;
      logic [31:0] addr;
      logic [31:0] w [8];
      logic [8*12-1:0] nm [4];
      logic [31:0] vl [4];
      fd = $fopen("femtoStim.txt", "r");
      if (fd == 0) begin
         $display("cannot open femtoStim.txt for reading");
         errors++;
      end else begin
         while ($fgets(line, fd) != 0) begin
            if (line.len() < 2 || line[0] == "#") continue;
            if (line[0] == "P") begin
               n = $sscanf(line, "P %h %h %h %h %h %h %h %h %h", addr,
                           w[0], w[1], w[2], w[3], w[4], w[5], w[6], w[7]);
               for (int i = 0; i < n - 1; i++) begin
                  UUT.ram[(addr >> 2) + i] = w[i];  // Word-addressed RAM
               end
            end else if (line[0] == "T") begin
               n = $sscanf(line, "T %s %h %s %h %s %h %s %h",
                           nm[0], vl[0], nm[1], vl[1], nm[2], vl[2], nm[3], vl[3]);
               for (int i = 0; i < n / 2; i++) begin
                  nameQ.push_back(nm[i]);
                  expQ.push_back(vl[i][`FEMTO_LED_WIDTH-1:0]);
               end
            end
         end
         $fclose(fd);
      end
   endtask

   task automatic checkLeds(input logic [8*12-1:0] name, input logic [7:0] exp);
      checks++;
      assert (leds === exp) else begin
         $display("[FAIL] %0s: expected %02h, actual %02h", name, exp, leds);
         errors++;
      end
   endtask

   // Stalled or runaway program
   initial begin
      wait (loaded);
      repeat (cyclesPerResult * (expQ.size() + 1)) @(posedge clk);
      $display("watchdog expired, the program stopped producing LED results");
      $display("errors: %0d of %0d checks", errors, checks);
      $display("tests failed");
      $finish;
   end

   initial begin
      logic [7:0] last;
      loadStim();
      loaded = 1'b1;
      if (expQ.size() == 0) begin
         $display("no expected values found in femtoStim.txt");
         errors++;
      end
      // Reset spans eight rising edges, leds checked between them
      for (int c = 1; c < 8; c++) begin
         @(negedge clk);
         checkLeds("reset", 8'h00);  // Cleared while reset is held
      end
      @(posedge clk);
      mem_rstrb <= 1'b0;  // Eighth edge still samples reset
      @(negedge clk);
      checkLeds("postReset", 8'h00);
      last = 8'h00;
      foreach (expQ[i]) begin
         // Results never repeat back to back so any change is the next one
         do @(negedge clk); while (leds === last);
         checkLeds(nameQ[i], expQ[i]);
         last = leds;
      end
      $display("errors: %0d of %0d checks", errors, checks);
      if (errors == 0) begin
         $display("all tests passed");
      end else begin
         $display("tests failed");
      end
      $finish;
   end

endmodule
